// File: hdl/rv_pkg.sv
package rv_pkg;

    parameter int xlen = 32;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // lui
    } alu_op_e;

    // same coding as the branch funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_NONE = 3'b010,   // unused funct3 slot
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_e;

    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_PC4  = 2'b01,
        WB_ALU  = 2'b10,
        WB_MEM  = 2'b11
    } wb_sel_e;

endpackage

// File: hdl/inst_decoder.sv
module inst_decoder (
    input  logic [rv_pkg::xlen-1:0] inst,
    output logic                    alu_a_sel,   // 1 rs1, 0 pc
    output logic                    alu_b_sel,   // 1 imm, 0 rs2
    output rv_pkg::alu_op_e         alu_op,
    output rv_pkg::branch_e         branch_cond,
    output logic                    jump,
    output logic                    is_jalr,
    output rv_pkg::wb_sel_e         wb_sel,
    output logic                    rd_we,
    output logic                    mem_rd_en,
    output logic                    mem_wr_en,
    output logic [2:0]              mem_funct3,
    output logic                    illegal
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    logic       write_en;   // before the x0 filter
    logic       alt_ok;     // funct3 values where funct7 = 0100000 exists
    logic       f7_check;   // funct7 has to be decoded

    assign opcode     = opcode_e'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign rd         = inst[11:7];
    assign mem_funct3 = funct3;

    assign alt_ok   = (funct3 == 3'b101) || (funct3 == 3'b000 && opcode == OPC_OP);
    assign f7_check = (opcode == OPC_OP) || (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        alu_a_sel   = 1'b1;
        alu_b_sel   = 1'b1;
        alu_op      = ALU_ADD;   // address and target adds
        branch_cond = BR_NONE;
        jump        = 1'b0;
        is_jalr     = 1'b0;
        wb_sel      = WB_NONE;
        write_en    = 1'b0;
        mem_rd_en   = 1'b0;
        mem_wr_en   = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            OPC_LUI: begin
                alu_op   = ALU_PASS_B;
                wb_sel   = WB_ALU;
                write_en = 1'b1;
            end
            OPC_AUIPC: begin
                alu_a_sel = 1'b0;
                wb_sel    = WB_ALU;
                write_en  = 1'b1;
            end
            OPC_JAL: begin
                alu_a_sel = 1'b0;
                jump      = 1'b1;
                wb_sel    = WB_PC4;
                write_en  = 1'b1;
            end
            OPC_JALR: begin
                jump     = 1'b1;
                is_jalr  = 1'b1;
                wb_sel   = WB_PC4;
                write_en = 1'b1;
                illegal  = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                alu_a_sel = 1'b0;   // pc + imm
                if (funct3[2:1] == 2'b01) begin
                    illegal = 1'b1;
                end else begin
                    branch_cond = branch_e'(funct3);
                end
            end
            OPC_LOAD: begin
                mem_rd_en = 1'b1;
                wb_sel    = WB_MEM;
                write_en  = 1'b1;
                illegal   = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                mem_wr_en = 1'b1;
                illegal   = funct3[2] || (funct3 == 3'b011);
            end
            OPC_OP_IMM, OPC_OP: begin
                alu_b_sel = (opcode == OPC_OP_IMM);
                wb_sel    = WB_ALU;
                write_en  = 1'b1;
                case (funct3)
                    3'b000:  alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                if (f7_check && !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 && alt_ok))) begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase

        // unsupported encodings retire as a no-op
        if (illegal) begin
            branch_cond = BR_NONE;
            jump        = 1'b0;
            is_jalr     = 1'b0;
            wb_sel      = WB_NONE;
            write_en    = 1'b0;
            mem_rd_en   = 1'b0;
            mem_wr_en   = 1'b0;
        end
    end

    assign rd_we = write_en && (rd != 5'd0);   // x0 never reported

endmodule

// File: hdl/imm_gen.sv
module imm_gen (
    input  logic [rv_pkg::xlen-1:0] inst,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(inst[6:0]);

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_JALR, OPC_OP_IMM: begin
                imm = {{(xlen-12){inst[31]}}, inst[31:20]};
            end
            OPC_STORE: begin
                imm = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            OPC_BRANCH: begin
                imm = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            OPC_JAL: begin
                imm = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;   // op and unknown opcodes
        endcase
    end

endmodule

// File: hdl/exec_unit.sv
module exec_unit (
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic                    alu_a_sel,
    input  logic                    alu_b_sel,
    input  rv_pkg::alu_op_e         alu_op,
    output logic [rv_pkg::xlen-1:0] alu_out
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;

    assign op_a  = alu_a_sel ? rs1_data : pc;
    assign op_b  = alu_b_sel ? imm : rs2_data;
    assign shamt = op_b[4:0];   // also the shamt field of slli/srli/srai

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = xlen'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = xlen'(op_a < op_b);
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

endmodule

// File: hdl/branch_unit.sv
module branch_unit (
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  rv_pkg::branch_e         branch_cond,
    output logic                    taken
);
    import rv_pkg::*;

    always_comb begin
        case (branch_cond)
            BR_BEQ:  taken = (rs1_data == rs2_data);
            BR_BNE:  taken = (rs1_data != rs2_data);
            BR_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_BLTU: taken = (rs1_data < rs2_data);
            BR_BGEU: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;   // not a branch
        endcase
    end

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    rd_we,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic [rv_pkg::xlen-1:0] wb_data,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= wb_data;
        end
    end

    // asynchronous reads, x0 hardwired
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: hdl/pc_unit.sv
module pc_unit #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    jump,
    input  logic                    taken,
    input  logic                    is_jalr,
    input  logic [rv_pkg::xlen-1:0] target,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] pc_plus4
);
    import rv_pkg::*;

    logic [xlen-1:0] next_pc;

    assign pc_plus4 = pc + xlen'(4);

    always_comb begin
        if (jump || taken) begin
            next_pc = is_jalr ? {target[xlen-1:1], 1'b0} : target;   // jalr drops bit 0
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// File: hdl/mem_writeback.sv
module mem_writeback #(
    parameter int dmem_words = 256
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    mem_rd_en,
    input  logic                    mem_wr_en,
    input  logic [2:0]              mem_funct3,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] store_data,
    input  logic [rv_pkg::xlen-1:0] alu_out,
    input  logic [rv_pkg::xlen-1:0] pc_plus4,
    input  rv_pkg::wb_sel_e         wb_sel,
    output logic [rv_pkg::xlen-1:0] wb_data
);
    import rv_pkg::*;

    localparam int idx_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    logic [xlen-1:0]  mem [dmem_words];
    logic [idx_w-1:0] word_idx;
    logic [3:0]       byte_en;
    logic [xlen-1:0]  wr_word;     // store data copied onto every lane
    logic [xlen-1:0]  rd_word;
    logic [7:0]       rd_byte;
    logic [15:0]      rd_half;
    logic [xlen-1:0]  load_data;

    assign word_idx = idx_w'((addr >> 2) % dmem_words);   // wraps

    always_comb begin
        case (mem_funct3[1:0])
            2'b00: begin
                byte_en = 4'b0001 << addr[1:0];
                wr_word = {4{store_data[7:0]}};
            end
            2'b01: begin
                byte_en = addr[1] ? 4'b1100 : 4'b0011;
                wr_word = {2{store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_word = store_data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    assign rd_word = mem[word_idx];
    assign rd_byte = rd_word[8*addr[1:0] +: 8];
    assign rd_half = addr[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        if (!mem_rd_en) begin
            load_data = '0;
        end else begin
            case (mem_funct3)
                3'b000:  load_data = {{(xlen-8){rd_byte[7]}}, rd_byte};    // lb
                3'b001:  load_data = {{(xlen-16){rd_half[15]}}, rd_half};  // lh
                3'b100:  load_data = {{(xlen-8){1'b0}}, rd_byte};          // lbu
                3'b101:  load_data = {{(xlen-16){1'b0}}, rd_half};         // lhu
                default: load_data = rd_word;
            endcase
        end
    end

    always_comb begin
        case (wb_sel)
            WB_PC4:  wb_data = pc_plus4;
            WB_ALU:  wb_data = alu_out;
            WB_MEM:  wb_data = load_data;
            default: wb_data = '0;
        endcase
    end

endmodule

// File: hdl/rv_core.sv
module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc   = '0,
    parameter int                      dmem_words = 256
) (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic [rv_pkg::xlen-1:0] pc,        // fetch address
    input  logic [rv_pkg::xlen-1:0] inst,      // returned combinationally for pc
    output logic                    rd_we,
    output logic [4:0]              rd_addr,
    output logic [rv_pkg::xlen-1:0] rd_data,
    output logic                    illegal
);
    import rv_pkg::*;

    logic            alu_a_sel;
    logic            alu_b_sel;
    alu_op_e         alu_op;
    branch_e         branch_cond;
    logic            jump;
    logic            is_jalr;
    wb_sel_e         wb_sel;
    logic            mem_rd_en;
    logic            mem_wr_en;
    logic [2:0]      mem_funct3;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_out;      // target and load/store address too
    logic            taken;
    logic [xlen-1:0] pc_plus4;

    assign rd_addr = inst[11:7];

    inst_decoder u_decoder (
        .inst        (inst),
        .alu_a_sel   (alu_a_sel),
        .alu_b_sel   (alu_b_sel),
        .alu_op      (alu_op),
        .branch_cond (branch_cond),
        .jump        (jump),
        .is_jalr     (is_jalr),
        .wb_sel      (wb_sel),
        .rd_we       (rd_we),
        .mem_rd_en   (mem_rd_en),
        .mem_wr_en   (mem_wr_en),
        .mem_funct3  (mem_funct3),
        .illegal     (illegal)
    );

    imm_gen u_imm (
        .inst (inst),
        .imm  (imm)
    );

    reg_file u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_we    (rd_we),
        .rs1_addr (inst[19:15]),
        .rs2_addr (inst[24:20]),
        .rd_addr  (inst[11:7]),
        .wb_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec (
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .pc        (pc),
        .imm       (imm),
        .alu_a_sel (alu_a_sel),
        .alu_b_sel (alu_b_sel),
        .alu_op    (alu_op),
        .alu_out   (alu_out)
    );

    branch_unit u_branch (
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .branch_cond (branch_cond),
        .taken       (taken)
    );

    pc_unit #(
        .reset_pc (reset_pc)
    ) u_pc (
        .clk      (clk),
        .arst_n   (arst_n),
        .jump     (jump),
        .taken    (taken),
        .is_jalr  (is_jalr),
        .target   (alu_out),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    mem_writeback #(
        .dmem_words (dmem_words)
    ) u_mem_wb (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_rd_en  (mem_rd_en),
        .mem_wr_en  (mem_wr_en),
        .mem_funct3 (mem_funct3),
        .addr       (alu_out),
        .store_data (rs2_data),
        .alu_out    (alu_out),
        .pc_plus4   (pc_plus4),
        .wb_sel     (wb_sel),
        .wb_data    (rd_data)    // also the register write data
    );

endmodule

// File: sim/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] reset_pc   = 32'h0;
    localparam int          max_cycles = 2000;   // about 5x what all programs need
    localparam logic [31:0] nop        = 32'h0000_0013;   // addi x0, x0, 0

    localparam logic [6:0] op_load   = 7'h03;
    localparam logic [6:0] op_store  = 7'h23;
    localparam logic [6:0] op_branch = 7'h63;
    localparam logic [6:0] op_jal    = 7'h6f;
    localparam logic [6:0] op_jalr   = 7'h67;
    localparam logic [6:0] op_imm    = 7'h13;
    localparam logic [6:0] op_op     = 7'h33;
    localparam logic [6:0] op_lui    = 7'h37;
    localparam logic [6:0] op_auipc  = 7'h17;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        rd_we;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        illegal;

    logic [31:0] imem [256];
    logic [7:0]  dm [64];       // data bytes from 0x100 upward
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    logic [31:0] ill_pc;
    int          wp;
    int          cycles = 0;
    int          err_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    rv_core #(
        .reset_pc   (reset_pc),
        .dmem_words (256)
    ) uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .pc      (pc),
        .inst    (inst),
        .rd_we   (rd_we),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .illegal (illegal)
    );

    assign inst = imem[pc[9:2]];   // instruction store, word addressed

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // RV32I integer result for funct3 and the funct7[5] bit
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = nop;
        end
        for (int i = 0; i < 64; i++) begin
            dm[i] = 8'h00;
        end
        wp = 0;
        exp_pc.delete();
        exp_rd.delete();
        exp_val.delete();
        ill_pc = '1;   // no illegal word expected
    endtask

    task automatic expect_wb(input logic [31:0] at_pc, input logic [4:0] rd,
                             input logic [31:0] val);
        exp_pc.push_back(at_pc);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
    endtask

    task automatic emit(input logic [31:0] word);
        imem[wp] = word;
        wp++;
    endtask

    task automatic emit_wb(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] val);
        expect_wb(32'(wp * 4), rd, val);
        emit(word);
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800;   // addi sign-extends the low part
        emit_wb(enc_u(hi[31:12], rd, op_lui), rd, {hi[31:12], 12'h000});
        emit_wb(enc_i(val[11:0], rd, 3'd0, rd, op_imm), rd, val);
    endtask

    // base register x1 holds 0x100
    task automatic store_op(input logic [2:0] f3, input logic [4:0] rs2, input logic [31:0] val,
                            input int off);
        for (int i = 0; i < (1 << f3); i++) begin
            dm[off + i] = val[8*i +: 8];
        end
        emit(enc_s(12'(off), rs2, 5'd1, f3));
    endtask

    task automatic load_op(input logic [2:0] f3, input logic [4:0] rd, input int off);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            v[8*i +: 8] = dm[off + i];
        end
        if (f3 == 3'b000) begin
            v = {{24{v[7]}}, v[7:0]};
        end else if (f3 == 3'b001) begin
            v = {{16{v[15]}}, v[15:0]};
        end
        emit_wb(enc_i(12'(off), 5'd1, f3, rd, op_load), rd, v);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_eq(pc, reset_pc, "pc during reset");
        @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic sample_cycle();
        check_eq(32'(illegal), 32'(pc == ill_pc), "illegal flag");
        if (rd_we) begin
            if (exp_pc.size() == 0) begin
                err_count++;
                $display("unexpected register write to x%0d at pc %h", rd_addr, pc);
            end else begin
                check_eq(pc, exp_pc.pop_front(), "write-back pc");
                check_eq(32'(rd_addr), 32'(exp_rd.pop_front()), "write-back rd");
                check_eq(rd_data, exp_val.pop_front(), "write-back data");
            end
        end
    endtask

    task automatic run_program(input string name);
        int errs_before;
        int idle;
        errs_before = err_count;
        idle = 0;
        imem[wp] = enc_j(21'd0, 5'd0);   // jal x0, 0 parks the core
        pulse_reset();
        while (exp_pc.size() > 0 || idle < 3) begin
            @(negedge clk);   // outputs settled mid cycle
            sample_cycle();
            if (exp_pc.size() == 0) begin
                idle++;
            end
        end
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        clear_program();
        for (int r = 0; r < 3; r++) begin
            a = $urandom();
            b = (r == 2) ? a : $urandom();   // last round with equal operands
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int f = 0; f < 8; f++) begin
                emit_wb(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd3), 5'd3, alu_ref(3'(f), 1'b0, a, b));
                if (f == 0 || f == 5) begin
                    emit_wb(enc_r(7'h20, 5'd2, 5'd1, 3'(f), 5'd3), 5'd3,
                            alu_ref(3'(f), 1'b1, a, b));
                end
            end
            for (int f = 0; f < 8; f++) begin
                imm = $urandom();
                imm = {{20{imm[11]}}, imm[11:0]};
                if (f == 1 || f == 5) begin
                    emit_wb(enc_i({7'h00, imm[4:0]}, 5'd1, 3'(f), 5'd3, op_imm), 5'd3,
                            alu_ref(3'(f), 1'b0, a, {27'b0, imm[4:0]}));
                end else begin
                    emit_wb(enc_i(imm[11:0], 5'd1, 3'(f), 5'd3, op_imm), 5'd3,
                            alu_ref(3'(f), 1'b0, a, imm));
                end
                if (f == 5) begin   // srai
                    emit_wb(enc_i({7'h20, imm[4:0]}, 5'd1, 3'd5, 5'd3, op_imm), 5'd3,
                            alu_ref(3'd5, 1'b1, a, {27'b0, imm[4:0]}));
                end
            end
        end
        run_program("alu");
    endtask

    task automatic test_memory();
        logic [31:0] w1;
        logic [31:0] w2;
        w1 = 32'h7e81_91a3;   // mixed signs in bytes and halves
        w2 = $urandom();
        clear_program();
        load_const(5'd1, 32'h100);
        load_const(5'd2, w1);
        load_const(5'd3, w2);
        store_op(3'd2, 5'd2, w1, 0);
        store_op(3'd2, 5'd3, w2, 4);
        store_op(3'd0, 5'd3, w2, 9);
        store_op(3'd0, 5'd2, w1, 11);
        store_op(3'd0, 5'd2, w1, 8);
        store_op(3'd0, 5'd3, w2, 10);
        store_op(3'd1, 5'd2, w1, 14);
        store_op(3'd1, 5'd3, w2, 12);
        for (int off = 0; off < 16; off++) begin
            load_op(3'b000, 5'd4, off);
            load_op(3'b100, 5'd4, off);
            if (off % 2 == 0) begin
                load_op(3'b001, 5'd4, off);
                load_op(3'b101, 5'd4, off);
            end
            if (off % 4 == 0) begin
                load_op(3'b010, 5'd4, off);
            end
        end
        run_program("memory");
    endtask

    // registers and data memory from earlier tests must be gone
    task automatic test_reset();
        clear_program();
        emit_wb(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd7), 5'd7, 32'h0);
        emit_wb(enc_i(12'h000, 5'd3, 3'd0, 5'd10, op_imm), 5'd10, 32'h0);
        emit_wb(enc_i(12'h100, 5'd0, 3'd2, 5'd12, op_load), 5'd12, 32'h0);
        run_program("reset");
    endtask

    task automatic test_branches();
        logic [31:0] vals [4] = '{32'd0, 32'hffff_fffb, 32'd3, 32'd7};
        int          pa [5] = '{2, 2, 3, 1, 2};
        int          pb [5] = '{2, 3, 2, 2, 1};
        int          marker;
        marker = 0;
        clear_program();
        for (int r = 1; r < 4; r++) begin
            load_const(5'(r), vals[r]);
        end
        for (int c = 0; c < 8; c++) begin
            if (c != 2 && c != 3) begin
                for (int p = 0; p < 5; p++) begin
                    marker++;
                    if (!br_ref(3'(c), vals[pa[p]], vals[pb[p]])) begin
                        expect_wb(32'(wp * 4 + 4), 5'd5, 32'(marker));
                    end
                    emit(enc_b(13'd8, 5'(pb[p]), 5'(pa[p]), 3'(c)));
                    emit(enc_i(12'(marker), 5'd0, 3'd0, 5'd5, op_imm));   // fall-through path
                    emit_wb(enc_i(12'(marker), 5'd0, 3'd0, 5'd6, op_imm), 5'd6, 32'(marker));
                end
            end
        end
        run_program("branches");
    endtask

    task automatic test_jumps();
        logic [31:0] t;
        emit_wb(enc_i(12'd1, 5'd0, 3'd0, 5'd6, op_imm), 5'd6, 32'd1);
        emit_wb(enc_u(20'hfffff, 5'd7, op_auipc), 5'd7, 32'(wp * 4) + 32'hffff_f000);
        emit_wb(enc_u(20'h12345, 5'd7, op_auipc), 5'd7, 32'(wp * 4) + 32'h1234_5000);
        emit_wb(enc_j(21'd12, 5'd1), 5'd1, 32'(wp * 4 + 4));
        emit(enc_i(12'd99, 5'd0, 3'd0, 5'd5, op_imm));   // skipped
        emit(enc_i(12'd99, 5'd0, 3'd0, 5'd5, op_imm));
        t = 32'((wp + 4) * 4);
        load_const(5'd8, t + 32'd5);   // odd sum after the -4 offset
        emit_wb(enc_i(12'hffc, 5'd8, 3'd0, 5'd9, op_jalr), 5'd9, 32'(wp * 4 + 4));
        emit(enc_i(12'd99, 5'd0, 3'd0, 5'd5, op_imm));
        emit_wb(enc_i(12'd5, 5'd0, 3'd0, 5'd10, op_imm), 5'd10, 32'd5);
        run_program("jumps");
    endtask

    task automatic test_x0_illegal();
        clear_program();
        emit_wb(enc_i(12'h123, 5'd0, 3'd0, 5'd1, op_imm), 5'd1, 32'h123);
        emit(enc_i(12'd77, 5'd1, 3'd0, 5'd0, op_imm));
        emit(enc_u(20'habcde, 5'd0, op_lui));
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        emit_wb(enc_i(12'd0, 5'd0, 3'd0, 5'd5, op_imm), 5'd5, 32'h0);
        emit_wb(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd6), 5'd6, 32'h123);
        ill_pc = 32'(wp * 4);
        emit(32'h0000_0f8b);   // custom-0 opcode with rd = x31
        emit_wb(enc_i(12'd1, 5'd0, 3'd0, 5'd7, op_imm), 5'd7, 32'd1);
        run_program("x0_illegal");
    endtask

    initial begin
        void'($urandom(32'haeb3_4bfd));
        test_alu();
        test_memory();
        test_reset();
        test_branches();
        clear_program();
        test_jumps();
        test_x0_illegal();
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/rv_pkg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/exec_unit.sv
hdl/branch_unit.sv
hdl/reg_file.sv
hdl/pc_unit.sv
hdl/mem_writeback.sv
hdl/rv_core.sv
sim/tb_rv_core.sv

// File: Makefile
# Verilator flow for the single-cycle RV32I core

TOP       ?= tb_rv_core
SEED      ?= 1
LOG       ?= sim.log
OBJ       ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f build.f --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f build.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)
